// ==== source/stv_pkg.sv ====
// ==============================
// Shared types, register offsets and beam timing tables
// ==============================
`default_nettype none

package stv_pkg;

    typedef logic [6:0]  hcount_t;   // Beam ticks
    typedef logic [8:0]  vcount_t;   // Lines
    typedef logic [21:1] vaddr_t;    // Word address

    // Offsets within the FF82xx page
    typedef enum logic [7:0] {
        REG_BASE_HI  = 8'h00,
        REG_BASE_MID = 8'h02,
        REG_CNT_HI   = 8'h04,
        REG_CNT_MID  = 8'h06,
        REG_CNT_LO   = 8'h08,
        REG_SYNC     = 8'h0A,
        REG_BASE_LO  = 8'h0C,
        REG_LINE_OFS = 8'h0E,
        REG_MODE     = 8'h60
    } reg_sel_e;

    // ==============================
    // Horizontal timing
    // ==============================
    localparam hcount_t HLOAD_PAL        = 7'd1;
    localparam hcount_t HLOAD_NTSC       = 7'd2;
    localparam hcount_t HLOAD_MONO       = 7'd73;
    localparam hcount_t HSYNC_SET_COLOUR = 7'd101;
    localparam hcount_t HSYNC_RES_COLOUR = 7'd111;
    localparam hcount_t HSYNC_SET_MONO   = 7'd121;
    localparam hcount_t HSYNC_RES_MONO   = 7'd127;

    localparam hcount_t HDE_SET_PAL      = 7'd12;
    localparam hcount_t HDE_SET_NTSC     = 7'd11;
    localparam hcount_t HDE_SET_MONO     = 7'd2;
    localparam hcount_t HDE_RES_PAL      = 7'd96;
    localparam hcount_t HDE_RES_NTSC     = 7'd95;
    localparam hcount_t HDE_RES_MONO     = 7'd43;
    localparam hcount_t HBLANK_SET_PAL   = 7'd9;
    localparam hcount_t HBLANK_SET_NTSC  = 7'd8;
    localparam hcount_t HBLANK_RES       = 7'd114;

    // ==============================
    // Vertical timing
    // ==============================
    localparam vcount_t VLOAD_PAL        = 9'd200;
    localparam vcount_t VLOAD_NTSC       = 9'd250;
    localparam vcount_t VLOAD_MONO       = 9'd12;
    localparam vcount_t VSYNC_SET_COLOUR = 9'd508;
    localparam vcount_t VSYNC_SET_MONO   = 9'd510;

    localparam vcount_t VDE_SET_PAL      = 9'd62;
    localparam vcount_t VDE_SET_NTSC     = 9'd33;
    localparam vcount_t VDE_SET_MONO     = 9'd35;
    localparam vcount_t VDE_RES_PAL      = 9'd262;
    localparam vcount_t VDE_RES_NTSC     = 9'd233;
    localparam vcount_t VDE_RES_MONO     = 9'd435;
    localparam vcount_t VBLANK_SET_PAL   = 9'd24;
    localparam vcount_t VBLANK_SET_NTSC  = 9'd15;
    localparam vcount_t VBLANK_RES_PAL   = 9'd307;
    localparam vcount_t VBLANK_RES_NTSC  = 9'd257;

endpackage

`default_nettype wire

// ==== source/stv_interfaces.sv ====
// ==============================
// Mode and beam timing buses between the video blocks
// ==============================
`timescale 1ns/1ps
`default_nettype none

// Register contents seen by the generators
interface stv_mode_if;
    import stv_pkg::*;

    logic       mono;      // mde1
    logic       mde0;      // Readback only
    logic       pal;
    vaddr_t     base;
    logic [7:0] line_ofs;

    modport regs (output mono, mde0, pal, base, line_ofs);
    modport sink (input mono, mde0, pal, base, line_ofs);
endinterface

// Beam enables and window strobes
interface stv_beam_if;
    import stv_pkg::*;

    logic    tick_p;
    logic    tick_n;        // Half a tick after tick_p
    hcount_t hsc;
    logic    line_start;
    logic    frame_reload;  // High while vsync active
    logic    de;

    modport hgen  (output tick_p, tick_n, hsc, line_start);
    modport vgen  (input line_start, output frame_reload);
    modport degen (input tick_p, tick_n, hsc, line_start, frame_reload, output de);
    modport vcnt  (input tick_p, frame_reload, de);
endinterface

`default_nettype wire

// ==== source/stv_regs.sv ====
// ==============================
// Video register file, write decode and read mux
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stv_regs (
    input  wire logic           clk32,
    input  wire logic           porb,
    input  wire logic [7:0]     reg_addr_i,
    input  wire logic           reg_wr_i,
    input  wire logic           reg_rd_i,
    input  wire logic [15:0]    reg_wdata_i,
    output logic [15:0]         reg_rdata_o,
    input  wire stv_pkg::vaddr_t vid_addr_i,
    stv_mode_if.regs            mode
);
    import stv_pkg::*;

    logic       mono_q;
    logic       mde0_q;
    logic       pal_q;
    vaddr_t     base_q;
    logic [7:0] line_ofs_q;

    // Byte fields latched on write strobe
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            mono_q     <= 1'b0;
            mde0_q     <= 1'b0;
            pal_q      <= 1'b0;
            base_q     <= '0;
            line_ofs_q <= '0;
        end else if (reg_wr_i) begin
            case (reg_addr_i)
                REG_BASE_HI:  base_q[21:16] <= reg_wdata_i[5:0];
                REG_BASE_MID: base_q[15:8]  <= reg_wdata_i[7:0];
                REG_BASE_LO:  base_q[7:1]   <= reg_wdata_i[7:1];
                REG_LINE_OFS: line_ofs_q    <= reg_wdata_i[7:0];
                REG_SYNC:     pal_q         <= reg_wdata_i[9];
                REG_MODE:     {mono_q, mde0_q} <= reg_wdata_i[9:8];
                default: ;  // Counter regs are read only
            endcase
        end
    end

    // Unmapped offsets float high as on the real bus
    always_comb begin
        reg_rdata_o = 16'h0000;
        if (reg_rd_i) begin
            case (reg_addr_i)
                REG_BASE_HI:  reg_rdata_o = {10'd0, base_q[21:16]};
                REG_BASE_MID: reg_rdata_o = {8'd0, base_q[15:8]};
                REG_BASE_LO:  reg_rdata_o = {8'd0, base_q[7:1], 1'b0};
                REG_CNT_HI:   reg_rdata_o = {10'd0, vid_addr_i[21:16]};
                REG_CNT_MID:  reg_rdata_o = {8'd0, vid_addr_i[15:8]};
                REG_CNT_LO:   reg_rdata_o = {8'd0, vid_addr_i[7:1], 1'b0};
                REG_LINE_OFS: reg_rdata_o = {8'd0, line_ofs_q};
                REG_SYNC:     reg_rdata_o = {6'd0, pal_q, 9'd0};
                REG_MODE:     reg_rdata_o = {6'd0, mono_q, mde0_q, 8'd0};
                default:      reg_rdata_o = 16'hFFFF;
            endcase
        end
    end

    assign mode.mono     = mono_q;
    assign mode.mde0     = mde0_q;
    assign mode.pal      = pal_q;
    assign mode.base     = base_q;
    assign mode.line_ofs = line_ofs_q;

endmodule

`default_nettype wire

// ==== source/stv_hsync_gen.sv ====
// ==============================
// Beam tick divider and horizontal sync counter
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stv_hsync_gen #(
    parameter int TICK_DIV = 16
) (
    input  wire logic clk32,
    input  wire logic porb,
    stv_mode_if.sink  mode,
    stv_beam_if.hgen  beam,
    output logic      hsync_n_o
);
    import stv_pkg::*;

    localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CW-1:0] DIV_LAST = CW'(TICK_DIV - 1);
    localparam logic [CW-1:0] DIV_HALF = CW'(TICK_DIV / 2);

    logic [CW-1:0] div_cnt;
    logic          tick_p;
    logic          tick_n;
    hcount_t       hsc;
    logic          hsc_load;   // Second reload pending
    hcount_t       hload;
    hcount_t       hsync_set;
    hcount_t       hsync_res;

    // ==============================
    // Tick enables
    // ==============================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb)
            div_cnt <= '0;
        else if (div_cnt == DIV_LAST)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign tick_p = (div_cnt == '0);
    assign tick_n = (div_cnt == DIV_HALF);

    assign hload     = mode.mono ? HLOAD_MONO : (mode.pal ? HLOAD_PAL : HLOAD_NTSC);
    assign hsync_set = mode.mono ? HSYNC_SET_MONO : HSYNC_SET_COLOUR;
    assign hsync_res = mode.mono ? HSYNC_RES_MONO : HSYNC_RES_COLOUR;

    // ==============================
    // Horizontal counter
    // ==============================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hsc       <= '0;
            hsc_load  <= 1'b0;
            hsync_n_o <= 1'b1;
        end else if (tick_p) begin
            hsc <= hsc + 7'd1;
            if (hsc == 7'd127 || hsc_load) begin
                hsc_load <= ~hsc_load;   // Load value held for two ticks
                hsc      <= hload;
            end
            if (hsc == hsync_set) hsync_n_o <= 1'b0;
            if (hsc == hsync_res) hsync_n_o <= 1'b1;
        end
    end

    assign beam.tick_p     = tick_p;
    assign beam.tick_n     = tick_n;
    assign beam.hsc        = hsc;
    assign beam.line_start = tick_p & hsc_load;

endmodule

`default_nettype wire

// ==== source/stv_vsync_gen.sv ====
// ==============================
// Vertical line counter and vsync
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stv_vsync_gen (
    input  wire logic clk32,
    input  wire logic porb,
    stv_mode_if.sink  mode,
    stv_beam_if.vgen  beam,
    output logic      vsync_n_o
);
    import stv_pkg::*;

    vcount_t vsc;
    logic    vsc_load;
    vcount_t vload;
    vcount_t vsync_set;

    assign vload = mode.mono ? VLOAD_MONO : (mode.pal ? VLOAD_PAL : VLOAD_NTSC);
    assign vsync_set = mode.mono ? VSYNC_SET_MONO : VSYNC_SET_COLOUR;

    // One step per line, same double reload as horizontal
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vsc       <= '0;
            vsc_load  <= 1'b1;    // First line loads the counter
            vsync_n_o <= 1'b1;
        end else if (beam.line_start) begin
            vsc <= vsc + 9'd1;
            if (vsc == 9'd511 || vsc_load) begin
                vsc_load  <= ~vsc_load;
                vsc       <= vload;
                vsync_n_o <= 1'b1;
            end
            if (vsc == vsync_set) vsync_n_o <= 1'b0;
        end
    end

    assign beam.frame_reload = ~vsync_n_o;

endmodule

`default_nettype wire

// ==== source/stv_de_gen.sv ====
// ==============================
// Display enable and blank windows
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stv_de_gen (
    input  wire logic clk32,
    input  wire logic porb,
    stv_mode_if.sink  mode,
    stv_beam_if.degen beam,
    output logic      de_o,
    output logic      blank_n_o
);
    import stv_pkg::*;

    logic    cpal, cntsc;
    hcount_t hdec;
    vcount_t vdec;
    logic    hde, hblank;
    logic    vde, vblank;
    logic    hde_set, hde_reset, hblank_set, hblank_reset;
    logic    vde_set, vde_reset, vblank_set, vblank_reset;
    logic    vline;          // Once per line, at hsync end

    assign cpal  = ~mode.mono & mode.pal;
    assign cntsc = ~mode.mono & ~mode.pal;

    assign hde_set      = (cpal & hdec == HDE_SET_PAL) | (cntsc & hdec == HDE_SET_NTSC)
                        | (mode.mono & hdec == HDE_SET_MONO);
    assign hde_reset    = (cpal & hdec == HDE_RES_PAL) | (cntsc & hdec == HDE_RES_NTSC)
                        | (mode.mono & hdec == HDE_RES_MONO);
    assign hblank_set   = (cpal & hdec == HBLANK_SET_PAL) | (cntsc & hdec == HBLANK_SET_NTSC);
    assign hblank_reset = mode.mono | (hdec == HBLANK_RES);

    assign vde_set      = (cpal & vdec == VDE_SET_PAL) | (cntsc & vdec == VDE_SET_NTSC)
                        | (mode.mono & vdec == VDE_SET_MONO);
    assign vde_reset    = (cpal & vdec == VDE_RES_PAL) | (cntsc & vdec == VDE_RES_NTSC)
                        | (mode.mono & vdec == VDE_RES_MONO);
    assign vblank_set   = (cpal & vdec == VBLANK_SET_PAL) | (cntsc & vdec == VBLANK_SET_NTSC);
    assign vblank_reset = mode.mono | (cpal & vdec == VBLANK_RES_PAL)
                        | (cntsc & vdec == VBLANK_RES_NTSC);

    assign vline = beam.tick_p
                 & (beam.hsc == (mode.mono ? HSYNC_RES_MONO : HSYNC_RES_COLOUR));

    // ==============================
    // Horizontal window
    // ==============================
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            hdec   <= '0;
            hde    <= 1'b0;
            hblank <= 1'b0;
        end else if (beam.line_start) begin
            hdec   <= '0;
            hde    <= 1'b0;
            hblank <= 1'b0;
        end else if (beam.tick_n) begin
            hdec <= hdec + 7'd1;
            if (hblank_set)   hblank <= 1'b1;
            if (hblank_reset) hblank <= 1'b0;
            if (hde_reset)    hde    <= 1'b0;
            else if (hde_set) hde    <= 1'b1;
        end
    end

    // Vertical window, held clear through vsync
    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vdec   <= '0;
            vde    <= 1'b0;
            vblank <= 1'b0;
        end else if (beam.frame_reload) begin
            vdec   <= '0;
            vde    <= 1'b0;
            vblank <= 1'b0;
        end else if (vline) begin
            vdec <= vdec + 9'd1;
            if (vde_set)      vde    <= 1'b1;
            if (vde_reset)    vde    <= 1'b0;
            if (vblank_set)   vblank <= 1'b1;
            if (vblank_reset) vblank <= 1'b0;
        end
    end

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            de_o      <= 1'b0;
            blank_n_o <= 1'b1;
        end else if (beam.tick_p) begin
            de_o      <= hde & vde;
            blank_n_o <= hblank & vblank;
        end
    end

    assign beam.de = de_o;

endmodule

`default_nettype wire

// ==== source/stv_vid_counter.sv ====
// ==============================
// Video fetch word-address counter
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stv_vid_counter (
    input  wire logic       clk32,
    input  wire logic       porb,
    stv_mode_if.sink        mode,
    stv_beam_if.vcnt        beam,
    output stv_pkg::vaddr_t vid_addr_o
);
    import stv_pkg::*;

    logic   de_d;       // Previous cycle DE for edge detect
    vaddr_t line_step;

    assign line_step = {13'd0, mode.line_ofs};

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            vid_addr_o <= '0;
            de_d       <= 1'b0;
        end else begin
            de_d <= beam.de;
            if (beam.frame_reload)
                vid_addr_o <= mode.base;              // Reload each frame
            else if (beam.tick_p && beam.de)
                vid_addr_o <= vid_addr_o + 21'd1;     // One word per displayed tick
            else if (de_d && !beam.de)
                vid_addr_o <= vid_addr_o + line_step; // Skip to next line
        end
    end

endmodule

`default_nettype wire

// ==== source/stv_top.sv ====
// ==============================
// Video timing top level
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stv_top #(
    parameter int TICK_DIV = 16   // clk32 cycles per beam tick
) (
    input  wire logic        clk32,
    input  wire logic        porb,
    input  wire logic [7:0]  reg_addr_i,
    input  wire logic        reg_wr_i,
    input  wire logic        reg_rd_i,
    input  wire logic [15:0] reg_wdata_i,
    output logic [15:0]      reg_rdata_o,
    output logic             hsync_n_o,
    output logic             vsync_n_o,
    output logic             de_o,
    output logic             blank_n_o,
    output stv_pkg::vaddr_t  vid_addr_o
);

    stv_mode_if mode_bus ();
    stv_beam_if beam_bus ();

    stv_regs u_regs (
        .clk32       (clk32),
        .porb        (porb),
        .reg_addr_i  (reg_addr_i),
        .reg_wr_i    (reg_wr_i),
        .reg_rd_i    (reg_rd_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .vid_addr_i  (vid_addr_o),
        .mode        (mode_bus.regs)
    );

    stv_hsync_gen #(.TICK_DIV(TICK_DIV)) u_hsync (
        .clk32     (clk32),
        .porb      (porb),
        .mode      (mode_bus.sink),
        .beam      (beam_bus.hgen),
        .hsync_n_o (hsync_n_o)
    );

    stv_vsync_gen u_vsync (
        .clk32     (clk32),
        .porb      (porb),
        .mode      (mode_bus.sink),
        .beam      (beam_bus.vgen),
        .vsync_n_o (vsync_n_o)
    );

    stv_de_gen u_de (
        .clk32     (clk32),
        .porb      (porb),
        .mode      (mode_bus.sink),
        .beam      (beam_bus.degen),
        .de_o      (de_o),
        .blank_n_o (blank_n_o)
    );

    stv_vid_counter u_vcnt (
        .clk32      (clk32),
        .porb       (porb),
        .mode       (mode_bus.sink),
        .beam       (beam_bus.vcnt),
        .vid_addr_o (vid_addr_o)
    );

endmodule

`default_nettype wire

// ==== verification/stv_assertions.sv ====
// ==============================
// Bound checks on sync, blank and address counter
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stv_assertions (
    input wire logic            clk32,
    input wire logic            porb,
    input wire logic            line_start_i,
    input wire logic            frame_reload_i,
    input wire logic            mono_i,
    input wire logic            vsync_n_i,
    input wire logic            de_i,
    input wire logic            blank_n_i,
    input wire stv_pkg::vaddr_t vid_addr_i
);

    // vsync moves only on a line boundary
    a_vsync_on_line: assert property (@(posedge clk32) disable iff (!porb)
        $changed(vsync_n_i) |-> $past(line_start_i))
        else $error("vsync_n_o changed away from a line start");

    a_de_in_blank: assert property (@(posedge clk32) disable iff (!porb)
        (de_i && !mono_i) |-> blank_n_i)
        else $error("de_o high outside the blank window");

    // Counter moves on DE ticks, the DE fall or reload only
    a_addr_hold: assert property (@(posedge clk32) disable iff (!porb)
        (!frame_reload_i && !de_i && !$past(de_i)) |=> $stable(vid_addr_i))
        else $error("vid_addr_o moved outside display and vsync");

endmodule

bind stv_top stv_assertions u_assertions (
    .clk32          (clk32),
    .porb           (porb),
    .line_start_i   (beam_bus.line_start),
    .frame_reload_i (beam_bus.frame_reload),
    .mono_i         (mode_bus.mono),
    .vsync_n_i      (vsync_n_o),
    .de_i           (de_o),
    .blank_n_i      (blank_n_o),
    .vid_addr_i     (vid_addr_o)
);

`default_nettype wire

// ==== verification/stv_tb.sv ====
// ==============================
// Video timing testbench, register port and beam measurements
// ==============================
`timescale 1ns/1ps
`default_nettype none

module stv_tb;

    localparam int WAIT_LIMIT = 1_000_000;   // clk32 cycles per wait
    localparam int T_REGS  = 0;
    localparam int T_LINE  = 1;
    localparam int T_FRAME = 2;
    localparam int T_WIN   = 3;
    localparam int T_ADDR  = 4;

    // Writable registers and the bits that read back
    localparam logic [7:0]  RW_ADDR [6] = '{8'h00, 8'h02, 8'h0C, 8'h0E, 8'h0A, 8'h60};
    localparam logic [15:0] RW_MASK [6] = '{16'h003F, 16'h00FF, 16'h00FE,
                                            16'h00FF, 16'h0200, 16'h0300};

    logic        clk32;
    logic        porb;
    logic [7:0]  reg_addr;
    logic        reg_wr;
    logic        reg_rd;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;
    logic        hsync_n;
    logic        vsync_n;
    logic        de;
    logic        blank_n;
    logic [21:1] vid_addr;

    integer seed;
    int     errs [5];
    int     tests_run;
    int     tests_failed;
    logic   timed_out;

    stv_top #(.TICK_DIV(16)) dut0 (
        .clk32       (clk32),
        .porb        (porb),
        .reg_addr_i  (reg_addr),
        .reg_wr_i    (reg_wr),
        .reg_rd_i    (reg_rd),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata),
        .hsync_n_o   (hsync_n),
        .vsync_n_o   (vsync_n),
        .de_o        (de),
        .blank_n_o   (blank_n),
        .vid_addr_o  (vid_addr)
    );

    initial begin
        clk32 = 1'b0;
        forever #50 clk32 = ~clk32;
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic void expected_frame(
        input  logic        mono,
        input  logic        pal,
        input  logic [20:0] base,
        input  logic [7:0]  ofs,
        output int          line_ticks,
        output int          frame_lines,
        output int          hs_ticks,
        output int          de_ticks,
        output int          de_lines,
        output logic [20:0] end_addr
    );
        int hload;
        int vload;
        hload       = mono ? 73 : (pal ? 1 : 2);
        vload       = mono ? 12 : (pal ? 200 : 250);
        line_ticks  = 129 - hload;   // Load value twice, then up to 127
        frame_lines = 513 - vload;
        hs_ticks    = mono ? 127 - 121 : 111 - 101;
        de_ticks    = mono ? 43 - 2 : (pal ? 96 - 12 : 95 - 11);
        de_lines    = mono ? 435 - 35 : (pal ? 262 - 62 : 233 - 33);
        end_addr    = base + 21'(de_lines * (de_ticks + int'(ofs)));
    endfunction

    task automatic step();
        @(posedge clk32);
        #1;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        step();
        reg_wr    = 1'b0;
    endtask

    // Combinational read, no clock edge consumed
    task automatic read_reg(input logic [7:0] addr, output logic [15:0] data);
        reg_addr = addr;
        reg_rd   = 1'b1;
        #1;
        data     = reg_rdata;
        reg_rd   = 1'b0;
    endtask

    task automatic read_counter(output logic [20:0] value);
        logic [15:0] hi;
        logic [15:0] mid;
        logic [15:0] lo;
        read_reg(8'h04, hi);
        read_reg(8'h06, mid);
        read_reg(8'h08, lo);
        value = {hi[5:0], mid[7:0], lo[7:1]};
    endtask

    task automatic check_equal(input int t, input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("Mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            errs[t]++;
        end
    endtask

    task automatic report_test(input string name, input int t);
        tests_run++;
        if (errs[t] == 0) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: FAIL with %0d error(s)", name, errs[t]);
            tests_failed++;
        end
        errs[t] = 0;
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout: %s", what);
        timed_out = 1'b1;
    endtask

    task automatic wait_vsync_fall();
        int   n;
        logic prev;
        logic found;
        n     = 0;
        found = 1'b0;
        while (!found && n < WAIT_LIMIT) begin
            prev  = vsync_n;
            step();
            n++;
            found = prev & ~vsync_n;
        end
        if (!found) note_timeout("vsync_n_o never fell");
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic check_regs();
        logic [31:0] rnd;
        logic [15:0] rd;
        for (int round = 0; round < 4; round++) begin
            for (int i = 0; i < 6; i++) begin
                rnd = $random(seed);
                write_reg(RW_ADDR[i], rnd[15:0]);
                read_reg(RW_ADDR[i], rd);
                check_equal(T_REGS, "register readback", int'(rd), int'(rnd[15:0] & RW_MASK[i]));
            end
        end
        read_reg(8'h10, rd);
        check_equal(T_REGS, "unmapped offset 10", int'(rd), 32'hFFFF);
        read_reg(8'h62, rd);
        check_equal(T_REGS, "unmapped offset 62", int'(rd), 32'hFFFF);
        report_test("Register readback", T_REGS);
    endtask

    // Called during vsync, returns right after the measured frame's vsync fall
    task automatic run_mode(input logic mono, input logic pal, input string name);
        logic [31:0] rnd;
        logic [20:0] base;
        logic [7:0]  ofs;
        logic [20:0] end_addr;
        logic [20:0] got_addr;
        logic [20:0] port_addr;
        int          line_ticks, frame_lines, hs_ticks, de_ticks, de_lines;
        int          n, line_cyc, hs_low, hs_cnt, de_run, de_cnt, blank_high;
        logic        prev_hs, prev_de, prev_vs, done, addr_taken;

        rnd  = $random(seed);
        base = rnd[20:0];
        rnd  = $random(seed);
        ofs  = rnd[7:0];
        expected_frame(mono, pal, base, ofs, line_ticks, frame_lines, hs_ticks,
                       de_ticks, de_lines, end_addr);

        write_reg(8'h60, {6'd0, mono, 1'b0, 8'd0});
        write_reg(8'h0A, {6'd0, pal, 9'd0});
        write_reg(8'h00, {10'd0, base[20:15]});
        write_reg(8'h02, {8'd0, base[14:7]});
        write_reg(8'h0C, {8'd0, base[6:0], 1'b0});
        write_reg(8'h0E, {8'd0, ofs});

        wait_vsync_fall();           // Skip the frame that held the switch
        if (timed_out) return;
        step();
        step();
        read_counter(got_addr);
        check_equal(T_ADDR, "counter during vsync", int'(got_addr), int'(base));
        check_equal(T_ADDR, "vid_addr_o during vsync", int'(vid_addr), int'(base));

        n          = 0;
        line_cyc   = 0;
        hs_low     = 0;
        hs_cnt     = 0;
        de_run     = 0;
        de_cnt     = 0;
        blank_high = 0;
        done       = 1'b0;
        addr_taken = 1'b0;
        port_addr  = '0;
        while (!done && n < WAIT_LIMIT) begin
            prev_hs = hsync_n;
            prev_de = de;
            prev_vs = vsync_n;
            step();
            n++;
            line_cyc++;
            if (prev_hs && !hsync_n) begin
                if (hs_cnt > 0)
                    check_equal(T_LINE, "cycles per line", line_cyc, line_ticks * 16);
                hs_cnt++;
                line_cyc = 0;
                hs_low   = 0;
                if (de_cnt == de_lines && !de && !addr_taken) begin
                    read_counter(got_addr);   // After the last display line
                    port_addr  = vid_addr;
                    addr_taken = 1'b1;
                end
            end
            if (!hsync_n) hs_low++;
            if (!prev_hs && hsync_n && hs_cnt > 0)
                check_equal(T_LINE, "hsync low cycles", hs_low, hs_ticks * 16);
            if (!prev_de && de) begin
                de_cnt++;
                de_run = 0;
            end
            if (de) de_run++;
            if (prev_de && !de)
                check_equal(T_WIN, "de_o high cycles", de_run, de_ticks * 16);
            if (mono && blank_n) blank_high++;
            done = prev_vs & ~vsync_n;
        end
        if (!done) begin
            note_timeout("frame did not end");
            return;
        end

        check_equal(T_FRAME, "hsync pulses per frame", hs_cnt, frame_lines);
        check_equal(T_WIN, "display lines per frame", de_cnt, de_lines);
        if (mono)
            check_equal(T_WIN, "blank_n_o high cycles", blank_high, 0);
        assert (addr_taken) else begin
            $display("Counter was never read after the last display line in %s", name);
            errs[T_ADDR]++;
        end
        if (addr_taken) begin
            check_equal(T_ADDR, "counter after display", int'(got_addr), int'(end_addr));
            check_equal(T_ADDR, "vid_addr_o after display", int'(port_addr), int'(end_addr));
        end

        report_test({name, " line length"}, T_LINE);
        report_test({name, " frame length"}, T_FRAME);
        report_test({name, " display window"}, T_WIN);
        report_test({name, " address counter"}, T_ADDR);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        seed         = 32'h74dc675a;
        porb         = 1'b0;
        reg_addr     = 8'h00;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_wdata    = 16'h0000;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        foreach (errs[i]) errs[i] = 0;

        repeat (8) @(posedge clk32);
        #1 porb = 1'b1;

        wait_vsync_fall();
        if (!timed_out) check_regs();   // Mode writes stay inside vsync
        if (!timed_out) run_mode(1'b0, 1'b1, "PAL");
        if (!timed_out) run_mode(1'b0, 1'b0, "NTSC");
        if (!timed_out) run_mode(1'b1, 1'b0, "Mono");

        $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0 && !timed_out)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/stv_pkg.sv
source/stv_interfaces.sv
source/stv_regs.sv
source/stv_hsync_gen.sv
source/stv_vsync_gen.sv
source/stv_de_gen.sv
source/stv_vid_counter.sv
source/stv_top.sv
verification/stv_assertions.sv
verification/stv_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the video timing testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module stv_tb -Mdir obj_dir -o stv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/stv_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$log"; then
    exit 0
fi
echo "Simulation did not report success, see $log"
exit 1
